// ==== source/pool_mif_pkg.sv ====
package pool_mif_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Pooling cores sharing the buffer
    localparam int pool_core = 4;
    localparam int core_w = 2;

    // Buffer address width, 64 words
    localparam int idx_width = 6;

    // One feature-map word is comp_lanes activations
    localparam int act_width = 8;
    localparam int comp_lanes = 4;
    localparam int fm_width = act_width * comp_lanes;

    // Queue depth of four
    localparam int fifo_depth_log2 = 2;

    // Command entry, tag above address
    typedef struct packed {
        logic [core_w-1:0]    port;
        logic [idx_width-1:0] addr;
    } cmd_entry_t;

    // Response entry, tag above data
    typedef struct packed {
        logic [core_w-1:0]   port;
        logic [fm_width-1:0] data;
    } fm_entry_t;

endpackage

// ==== source/prior_arb.sv ====
`timescale 1ns/1ps

module prior_arb (
    input  logic [pool_mif_pkg::pool_core-1:0] req,
    output logic [pool_mif_pkg::pool_core-1:0] gnt,
    output logic [pool_mif_pkg::core_w-1:0]    gnt_idx
);

    // Lowest index wins
    // Scan from the top so the last hit is the lowest active bit
    always_comb begin
        gnt = '0;
        gnt_idx = '0;
        for (int i = pool_mif_pkg::pool_core - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt = '0;
                gnt[i] = 1'b1;
                gnt_idx = i[pool_mif_pkg::core_w-1:0];
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Grant is the lowest set request bit, idle only with no request
    // Index names the granted bit
    always_comb begin
        if (!$isunknown(req)) begin
            assert ((gnt == (req & (~req + 1'b1))) && ((req == '0) || gnt[gnt_idx]))
                else $error("prior_arb: bad grant %b idx %0d for req %b", gnt, gnt_idx, req);
        end
    end

endmodule

// ==== source/fifo_fwft.sv ====
`timescale 1ns/1ps

module fifo_fwft #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    // Entry storage
    payload_t mem [2**pool_mif_pkg::fifo_depth_log2];

    // Pointers wrap on their own width
    logic [pool_mif_pkg::fifo_depth_log2-1:0] wr_ptr;
    logic [pool_mif_pkg::fifo_depth_log2-1:0] rd_ptr;

    // One extra bit so a full queue is distinct from empty
    logic [pool_mif_pkg::fifo_depth_log2:0] count;

    logic do_push;
    logic do_pop;

    // Qualified strobes
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Head shows without a pop
    assign data_out = mem[rd_ptr];

    // Count MSB set only at depth
    assign empty = (count == '0);
    assign full = count[pool_mif_pkg::fifo_depth_log2];

    // ==============================
    // Storage and pointers
    // ==============================

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Caller must respect the flags
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("fifo_fwft: push while full");

    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("fifo_fwft: pop while empty");

endmodule

// ==== source/glb_bank.sv ====
`timescale 1ns/1ps

module glb_bank (
    input  logic                              clk,
    input  logic                              rst_n,
    // Load port
    input  logic                              wr_en,
    input  logic [pool_mif_pkg::idx_width-1:0] wr_addr,
    input  logic [pool_mif_pkg::fm_width-1:0]  wr_data,
    // Read address port
    input  logic                              addr_vld,
    input  logic [pool_mif_pkg::idx_width-1:0] addr,
    output logic                              addr_rdy,
    // Read data port
    output logic [pool_mif_pkg::fm_width-1:0]  fm,
    output logic                              fm_vld,
    input  logic                              fm_rdy
);

    // Word array
    logic [pool_mif_pkg::fm_width-1:0] mem [2**pool_mif_pkg::idx_width];

    logic rd_acc;

    // ==============================
    // Write port
    // ==============================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ==============================
    // Read port
    // ==============================

    // Free when nothing held or held word leaves now
    assign addr_rdy = !fm_vld || fm_rdy;
    assign rd_acc = addr_vld && addr_rdy;

    // Output register, one cycle after accept
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            fm <= mem[addr];
        end
    end

    // Valid stays up across back-to-back reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_vld <= 1'b0;
        end else if (rd_acc) begin
            fm_vld <= 1'b1;
        end else if (fm_rdy) begin
            fm_vld <= 1'b0;
        end
    end

    // Held word must not move while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        (fm_vld && !fm_rdy) |=> (fm_vld && $stable(fm)))
        else $error("glb_bank: read data changed under back-pressure");

endmodule

// ==== source/pool_mif.sv ====
`timescale 1ns/1ps

module pool_mif (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    // Core requests
    input  logic [pool_mif_pkg::pool_core-1:0]                   req_vld,
    input  logic [pool_mif_pkg::pool_core*pool_mif_pkg::idx_width-1:0] req_addr,
    output logic [pool_mif_pkg::pool_core-1:0]                   req_rdy,
    // Buffer address
    output logic                                                 glb_addr_vld,
    output logic [pool_mif_pkg::idx_width-1:0]                   glb_addr,
    input  logic                                                 glb_addr_rdy,
    // Buffer data
    input  logic [pool_mif_pkg::fm_width-1:0]                    glb_fm,
    input  logic                                                 glb_fm_vld,
    output logic                                                 glb_fm_rdy,
    // Output stream
    output logic                                                 fm_vld,
    output logic [pool_mif_pkg::core_w-1:0]                      fm_port,
    output logic [pool_mif_pkg::fm_width-1:0]                    fm_data,
    input  logic                                                 fm_rdy
);

    logic [pool_mif_pkg::pool_core-1:0] gnt;
    logic [pool_mif_pkg::core_w-1:0]    gnt_idx;

    pool_mif_pkg::cmd_entry_t cmd_in;
    pool_mif_pkg::cmd_entry_t cmd_head;
    logic                     cmd_push;
    logic                     cmd_pop;
    logic                     cmd_empty;
    logic                     cmd_full;

    pool_mif_pkg::fm_entry_t out_in;
    pool_mif_pkg::fm_entry_t out_head;
    logic                    out_push;
    logic                    out_pop;
    logic                    out_empty;
    logic                    out_full;

    // Tag of the read now in the buffer
    logic [pool_mif_pkg::core_w-1:0] rd_tag;

    // ==============================
    // Request arbitration
    // ==============================

    prior_arb u_prior_arb (
        .req     (req_vld),
        .gnt     (gnt),
        .gnt_idx (gnt_idx)
    );

    // Winner only, and only with queue room
    assign req_rdy = gnt & {pool_mif_pkg::pool_core{!cmd_full}};
    assign cmd_push = |req_rdy;

    // Winner's address slice with its tag
    assign cmd_in.port = gnt_idx;
    assign cmd_in.addr = req_addr[int'(gnt_idx)*pool_mif_pkg::idx_width +: pool_mif_pkg::idx_width];

    // ==============================
    // Command queue
    // ==============================

    fifo_fwft #(
        .payload_t (pool_mif_pkg::cmd_entry_t)
    ) u_cmd_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (cmd_push),
        .pop      (cmd_pop),
        .data_in  (cmd_in),
        .data_out (cmd_head),
        .empty    (cmd_empty),
        .full     (cmd_full)
    );

    // Head goes straight to the buffer
    assign glb_addr_vld = !cmd_empty;
    assign glb_addr = cmd_head.addr;
    assign cmd_pop = glb_addr_vld && glb_addr_rdy;

    // At most one read in flight, so one tag register is enough
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_tag <= '0;
        end else if (cmd_pop) begin
            rd_tag <= cmd_head.port;
        end
    end

    // ==============================
    // Output queue
    // ==============================

    assign glb_fm_rdy = !out_full;
    assign out_push = glb_fm_vld && glb_fm_rdy;
    assign out_in.port = rd_tag;
    assign out_in.data = glb_fm;

    fifo_fwft #(
        .payload_t (pool_mif_pkg::fm_entry_t)
    ) u_out_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (out_push),
        .pop      (out_pop),
        .data_in  (out_in),
        .data_out (out_head),
        .empty    (out_empty),
        .full     (out_full)
    );

    // Output stream from queue head
    assign fm_vld = !out_empty;
    assign fm_port = out_head.port;
    assign fm_data = out_head.data;
    assign out_pop = fm_vld && fm_rdy;

    // Tag pairing relies on buffer data one cycle after the address accept
    assert property (@(posedge clk) disable iff (!rst_n) cmd_pop |=> glb_fm_vld)
        else $error("pool_mif: buffer read data late");

endmodule

// ==== source/pool_mem_top.sv ====
`timescale 1ns/1ps

module pool_mem_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    // Core requests
    input  logic [pool_mif_pkg::pool_core-1:0]                   req_vld,
    input  logic [pool_mif_pkg::pool_core*pool_mif_pkg::idx_width-1:0] req_addr,
    output logic [pool_mif_pkg::pool_core-1:0]                   req_rdy,
    // Buffer load
    input  logic                                                 wr_en,
    input  logic [pool_mif_pkg::idx_width-1:0]                   wr_addr,
    input  logic [pool_mif_pkg::fm_width-1:0]                    wr_data,
    // Output stream
    output logic                                                 fm_vld,
    output logic [pool_mif_pkg::core_w-1:0]                      fm_port,
    output logic [pool_mif_pkg::fm_width-1:0]                    fm_data,
    input  logic                                                 fm_rdy
);

    // Interface to buffer
    logic                              glb_addr_vld;
    logic [pool_mif_pkg::idx_width-1:0] glb_addr;
    logic                              glb_addr_rdy;

    // Buffer to interface
    logic [pool_mif_pkg::fm_width-1:0] glb_fm;
    logic                             glb_fm_vld;
    logic                             glb_fm_rdy;

    pool_mif u_pool_mif (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (req_vld),
        .req_addr     (req_addr),
        .req_rdy      (req_rdy),
        .glb_addr_vld (glb_addr_vld),
        .glb_addr     (glb_addr),
        .glb_addr_rdy (glb_addr_rdy),
        .glb_fm       (glb_fm),
        .glb_fm_vld   (glb_fm_vld),
        .glb_fm_rdy   (glb_fm_rdy),
        .fm_vld       (fm_vld),
        .fm_port      (fm_port),
        .fm_data      (fm_data),
        .fm_rdy       (fm_rdy)
    );

    // Single bank, loaded by the write port
    glb_bank u_glb_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .addr_vld (glb_addr_vld),
        .addr     (glb_addr),
        .addr_rdy (glb_addr_rdy),
        .fm       (glb_fm),
        .fm_vld   (glb_fm_vld),
        .fm_rdy   (glb_fm_rdy)
    );

endmodule

// ==== dv/tb_pool_mem.sv ====
`timescale 1ns/1ps

module tb_pool_mem;

    localparam int cores = pool_mif_pkg::pool_core;
    localparam int aw = pool_mif_pkg::idx_width;
    localparam int dw = pool_mif_pkg::fm_width;
    localparam int num_rows = 7;
    // Cycles a row gets to empty out after its last request
    localparam int drain_slack = 64;
    localparam logic [31:0] seed = 32'h6beee10d;
    localparam logic [aw-1:0] addr_step = 1;

    // One stimulus row, addresses packed core 3 down to core 0
    typedef struct packed {
        logic [cores-1:0]    mask;
        logic [cores*aw-1:0] addrs;
        logic [7:0]          hold;
        logic [7:0]          duty;
        logic                chk_stall;
    } row_t;

    logic                            clk;
    logic                            rst_n;
    logic [cores-1:0]                req_vld;
    logic [cores*aw-1:0]             req_addr;
    logic [cores-1:0]                req_rdy;
    logic                            wr_en;
    logic [aw-1:0]                   wr_addr;
    logic [dw-1:0]                   wr_data;
    logic                            fm_vld;
    logic [pool_mif_pkg::core_w-1:0] fm_port;
    logic [dw-1:0]                   fm_data;
    logic                            fm_rdy;

    row_t          table_rows [num_rows];
    // Copy of the buffer contents
    logic [dw-1:0] mem_model [2**aw];
    // Expected words per core, in issue order
    logic [dw-1:0] exp_q [cores][$];

    int errors = 0;
    int issued = 0;
    int returned = 0;
    int cycles = 0;
    int cycle_limit = 0;
    bit seen_req = 1'b0;

    pool_mem_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_vld  (req_vld),
        .req_addr (req_addr),
        .req_rdy  (req_rdy),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .fm_vld   (fm_vld),
        .fm_port  (fm_port),
        .fm_data  (fm_data),
        .fm_rdy   (fm_rdy)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic row_t make_row(input logic [cores-1:0] mask,
                                      input logic [aw-1:0] a3, a2, a1, a0,
                                      input int hold, input logic [7:0] duty,
                                      input logic chk_stall);
        row_t r;
        r.mask = mask;
        r.addrs = {a3, a2, a1, a0};
        r.hold = hold[7:0];
        r.duty = duty;
        r.chk_stall = chk_stall;
        return r;
    endfunction

    function automatic bit queues_empty();
        for (int c = 0; c < cores; c++) begin
            if (exp_q[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic int longest_row();
        int m;
        m = 0;
        for (int r = 0; r < num_rows; r++) begin
            if (int'(table_rows[r].hold) > m) begin
                m = int'(table_rows[r].hold);
            end
        end
        return m + drain_slack;
    endfunction

    // Mask, addresses of cores 3..0, hold cycles, fm_rdy pattern, stall expected
    task automatic fill_table();
        table_rows[0] = make_row(4'b0001, 0, 0, 0, 5, 10, 8'hff, 1'b0);
        table_rows[1] = make_row(4'b0100, 0, 40, 0, 0, 10, 8'hff, 1'b0);
        // Core 3 runs past the top address and wraps
        table_rows[2] = make_row(4'b1000, 62, 0, 0, 0, 8, 8'b10101010, 1'b0);
        table_rows[3] = make_row(4'b1111, 48, 32, 16, 0, 24, 8'hff, 1'b0);
        table_rows[4] = make_row(4'b1111, 7, 21, 35, 49, 30, 8'b00010001, 1'b0);
        // Long stretch with no fm_rdy
        table_rows[5] = make_row(4'b0011, 0, 0, 60, 10, 40, 8'h00, 1'b1);
        table_rows[6] = make_row(4'b1010, 30, 0, 44, 0, 16, 8'b11001100, 1'b0);
    endtask

    // Every word through the write port
    task automatic load_buffer();
        logic [31:0] state;
        state = seed;
        for (int a = 0; a < 2**aw; a++) begin
            @(posedge clk);
            state = next_rand(state);
            mem_model[a] = state;
            wr_en <= 1'b1;
            wr_addr <= a[aw-1:0];
            wr_data <= state;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // ==============================
    // Row driver
    // ==============================

    task automatic run_row(input int r);
        row_t                row;
        logic [cores-1:0]    live;
        logic [cores*aw-1:0] addr_bus;
        int                  cyc;
        int                  stalls;
        int                  err0;
        int                  iss0;
        int                  ret0;
        row = table_rows[r];
        err0 = errors;
        iss0 = issued;
        ret0 = returned;
        live = row.mask;
        addr_bus = row.addrs;
        cyc = 0;
        stalls = 0;
        @(posedge clk);
        req_vld <= live;
        req_addr <= addr_bus;
        fm_rdy <= row.duty[0];
        // A core keeps its request up until accepted
        while (live != '0) begin
            @(posedge clk);
            cyc++;
            if (req_vld != '0 && (req_vld & req_rdy) == '0) begin
                stalls++;
            end
            for (int c = 0; c < cores; c++) begin
                if (req_vld[c] && req_rdy[c]) begin
                    addr_bus[c*aw +: aw] = addr_bus[c*aw +: aw] + addr_step;
                    if (cyc >= int'(row.hold)) begin
                        live[c] = 1'b0;
                    end
                end
            end
            req_vld <= live;
            req_addr <= addr_bus;
            // Pattern only inside the hold window, then release
            fm_rdy <= (cyc < int'(row.hold)) ? row.duty[cyc % 8] : 1'b1;
        end
        for (int i = 0; i < drain_slack && !queues_empty(); i++) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (row.chk_stall) begin
            assert (stalls > 0) else begin
                $display("Back-pressure in row %0d never withheld req_rdy", r);
                errors++;
            end
        end
        $display("Row %0d: mask %b, %0d issued, %0d returned, %0d stall cycles, %s",
                 r, row.mask, issued - iss0, returned - ret0, stalls,
                 (errors == err0) ? "ok" : "errors");
    endtask

    // ==============================
    // Scoreboard and checks
    // ==============================

    always @(posedge clk) begin
        // Quiet outputs through reset and up to the first request
        if (!seen_req && req_vld == '0) begin
            assert (!fm_vld && req_rdy == '0) else begin
                $display("Mismatch at %0t: fm_vld %b req_rdy %b before any request",
                         $time, fm_vld, req_rdy);
                errors++;
            end
        end
        if (req_vld != '0) begin
            seen_req = 1'b1;
        end
        if (rst_n) begin
            assert ($onehot0(req_rdy) && (req_rdy & ~req_vld) == '0) else begin
                $display("Mismatch at %0t: req_rdy %b for req_vld %b",
                         $time, req_rdy, req_vld);
                errors++;
            end
            // Expected word taken at the request handshake
            for (int c = 0; c < cores; c++) begin
                if (req_vld[c] && req_rdy[c]) begin
                    exp_q[c].push_back(mem_model[req_addr[c*aw +: aw]]);
                    issued++;
                end
            end
            if (fm_vld && fm_rdy) begin
                returned++;
                if (exp_q[fm_port].size() == 0) begin
                    $display("Extra response on port %0d at %0t, nothing was requested",
                             fm_port, $time);
                    errors++;
                end else begin
                    assert (fm_data == exp_q[fm_port][0]) else begin
                        $display("Mismatch at %0t: port %0d data %h, expected %h",
                                 $time, fm_port, fm_data, exp_q[fm_port][0]);
                        errors++;
                    end
                    void'(exp_q[fm_port].pop_front());
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n = 1'b0;
        req_vld = '0;
        req_addr = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        fm_rdy = 1'b0;
        fill_table();
        cycle_limit = num_rows * longest_row() * 4;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        load_buffer();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (4) @(posedge clk);
        // Leftovers mean lost responses
        for (int c = 0; c < cores; c++) begin
            assert (exp_q[c].size() == 0) else begin
                $display("Missing responses: core %0d still waits for %0d words",
                         c, exp_q[c].size());
                errors++;
            end
        end
        $display("Summary: %0d rows, %0d requests issued, %0d responses, %0d errors",
                 num_rows, issued, returned, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/pool_mif_pkg.sv
source/prior_arb.sv
source/fifo_fwft.sv
source/glb_bank.sv
source/pool_mif.sv
source/pool_mem_top.sv
dv/tb_pool_mem.sv

// ==== Makefile ====
# Verilator build and run for the pool memory interface

VERILATOR  ?= verilator
TOP        ?= tb_pool_mem
RTL_TOP    ?= pool_mem_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= -Wno-fatal
LINT_FLAGS ?= -Wall
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		--top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) \
		--top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
